// ==== include/lsu_defs.svh ====
// widths, queue depth and exception cause codes for the load/store front end
// included by the package and by every module that sizes a signal from it
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------
// virtual address width
`define LSU_VLEN 64
// data and operand width
`define LSU_XLEN 64
// scoreboard id width
`define LSU_TRANS_ID_BITS 3

// sv39: bits from here upward must all match under translation
`define LSU_CANON_MSB 38

// bypass queue entries
`define LSU_QUEUE_DEPTH 2

// ----------------------------------------------------------------------
// mcause codes
// ----------------------------------------------------------------------
`define LSU_CAUSE_LD_MISALIGNED 4
`define LSU_CAUSE_LD_ACCESS 5
`define LSU_CAUSE_ST_MISALIGNED 6
`define LSU_CAUSE_ST_ACCESS 7

`endif

// ==== rtl/lsu_pkg.sv ====
// types shared by the load/store front end
// modules refer to them by scoped names
`include "lsu_defs.svh"

package lsu_pkg;

    // target unit of an issued operation
    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE
    } fu_t;

    // kept load and store operators
    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD
    } op_t;

    // transfer size
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } size_t;

    // operation as issued
    typedef struct packed {
        fu_t                           fu;
        op_t                           operator;
        logic [`LSU_XLEN-1:0]          operand_a;
        logic [`LSU_XLEN-1:0]          operand_b;
        logic [`LSU_XLEN-1:0]          imm;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // queue entry, everything dispatch needs later
    typedef struct packed {
        logic                          valid;
        fu_t                           fu;
        op_t                           operator;
        size_t                         size;
        logic [`LSU_VLEN-1:0]          vaddr;
        logic [`LSU_XLEN-1:0]          wdata;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
        // sampled at issue
        logic                          canon_fault;
    } lsu_ctrl_t;

    // request towards load or store unit
    typedef struct packed {
        logic                          valid;
        logic [`LSU_VLEN-1:0]          vaddr;
        logic [`LSU_XLEN-1:0]          wdata;
        logic [7:0]                    be;
        size_t                         size;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`LSU_XLEN-1:0] cause;
        logic [`LSU_XLEN-1:0] tval;
    } exception_t;

endpackage

// ==== rtl/lsu_agu.sv ====
// address generation for issued memory operations
// base plus signed immediate, plus the sv39 canonical-form check
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_agu (
    input  lsu_pkg::fu_data_t     fu_data_i,
    input  logic                  en_translation_i,
    output logic [`LSU_VLEN-1:0]  vaddr_o,
    output logic                  canon_fault_o
);

    // bits that must be a sign extension of bit CANON_MSB
    logic [`LSU_VLEN-1:`LSU_CANON_MSB] upper_bits;
    logic                              upper_ones;
    logic                              upper_zeros;

    // effective address, immediate already sign extended by issue
    assign vaddr_o = $unsigned($signed(fu_data_i.imm[`LSU_VLEN-1:0])
                             + $signed(fu_data_i.operand_a[`LSU_VLEN-1:0]));

    assign upper_bits  = vaddr_o[`LSU_VLEN-1:`LSU_CANON_MSB];
    assign upper_ones  = &upper_bits;
    assign upper_zeros = ~|upper_bits;

    // only meaningful with translation on
    // bare mode accepts any address
    assign canon_fault_o = en_translation_i & ~(upper_ones | upper_zeros);

endmodule

// ==== rtl/lsu_op_decode.sv ====
// operator decode into transfer size
// load or store kind already comes with the fu field
`timescale 1ns/1ps

module lsu_op_decode (
    input  lsu_pkg::op_t   operator_i,
    output lsu_pkg::size_t size_o
);

    always_comb begin : size_decode
        unique case (operator_i)
            // byte access
            lsu_pkg::LB,
            lsu_pkg::LBU,
            lsu_pkg::SB: begin
                size_o = lsu_pkg::BYTE;
            end
            // half word
            lsu_pkg::LH,
            lsu_pkg::LHU,
            lsu_pkg::SH: begin
                size_o = lsu_pkg::HALF;
            end
            // word, signed and unsigned
            lsu_pkg::LW,
            lsu_pkg::LWU,
            lsu_pkg::SW: begin
                size_o = lsu_pkg::WORD;
            end
            // double word
            lsu_pkg::LD,
            lsu_pkg::SD: begin
                size_o = lsu_pkg::DOUBLE;
            end
            // unused encodings fall back to full width
            default: begin
                size_o = lsu_pkg::DOUBLE;
            end
        endcase
    end

endmodule

// ==== rtl/lsu_bypass.sv ====
// two-entry queue between issue and the load/store units
// an empty queue passes the incoming entry straight to its output
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_bypass (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,

    input  lsu_pkg::lsu_ctrl_t lsu_req_i,
    input  logic               pop_ld_i,
    input  logic               pop_st_i,

    output lsu_pkg::lsu_ctrl_t lsu_ctrl_o,
    output logic               ready_o
);

    lsu_pkg::lsu_ctrl_t [`LSU_QUEUE_DEPTH-1:0] mem_n, mem_q;
    logic                                      rd_ptr_n, rd_ptr_q;
    logic                                      wr_ptr_n, wr_ptr_q;
    logic [1:0]                                status_cnt_n, status_cnt_q;
    logic                                      empty;

    assign empty   = (status_cnt_q == 2'd0);
    // issue may only present a new op while nothing is held
    assign ready_o = empty;

    // ----------------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------------
    always_comb begin : next_state
        mem_n        = mem_q;
        rd_ptr_n     = rd_ptr_q;
        wr_ptr_n     = wr_ptr_q;
        status_cnt_n = status_cnt_q;

        // always sample, the unit may refuse late in the cycle
        if (lsu_req_i.valid) begin
            mem_n[wr_ptr_q] = lsu_req_i;
            wr_ptr_n        = wr_ptr_q + 1'b1;
            status_cnt_n    = status_cnt_n + 2'd1;
        end

        // head consumed by load unit
        if (pop_ld_i) begin
            mem_n[rd_ptr_q].valid = 1'b0;
            rd_ptr_n              = rd_ptr_n + 1'b1;
            status_cnt_n          = status_cnt_n - 2'd1;
        end

        // head consumed by store unit
        if (pop_st_i) begin
            mem_n[rd_ptr_q].valid = 1'b0;
            rd_ptr_n              = rd_ptr_n + 1'b1;
            status_cnt_n          = status_cnt_n - 2'd1;
        end

        // both units done in one cycle, nothing left
        if (pop_ld_i && pop_st_i) begin
            mem_n = '0;
        end

        if (flush_i) begin
            mem_n        = '0;
            rd_ptr_n     = 1'b0;
            wr_ptr_n     = 1'b0;
            status_cnt_n = 2'd0;
        end
    end

    // head: bypass when empty, else oldest stored entry
    assign lsu_ctrl_o = empty ? lsu_req_i : mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_q        <= '0;
            rd_ptr_q     <= 1'b0;
            wr_ptr_q     <= 1'b0;
            status_cnt_q <= 2'd0;
        end else begin
            mem_q        <= mem_n;
            rd_ptr_q     <= rd_ptr_n;
            wr_ptr_q     <= wr_ptr_n;
            status_cnt_q <= status_cnt_n;
        end
    end

endmodule

// ==== rtl/lsu_dispatch.sv ====
// queue head to load or store request, with byte enables and exceptions
// purely combinational, outputs follow the head entry
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_dispatch (
    input  lsu_pkg::lsu_ctrl_t  lsu_ctrl_i,
    output lsu_pkg::mem_req_t   ld_req_o,
    output lsu_pkg::mem_req_t   st_req_o,
    output lsu_pkg::exception_t ex_o
);

    logic              is_load;
    logic              is_store;
    logic              misaligned;
    logic [7:0]        be;
    lsu_pkg::mem_req_t req;

    // contiguous lane run starting at the low address bits
    function automatic logic [7:0] be_gen(input lsu_pkg::size_t size,
                                          input logic [2:0]     offset);
        logic [7:0] lanes;
        case (size)
            lsu_pkg::BYTE:   lanes = 8'b0000_0001;
            lsu_pkg::HALF:   lanes = 8'b0000_0011;
            lsu_pkg::WORD:   lanes = 8'b0000_1111;
            default:         lanes = 8'b1111_1111;
        endcase
        return lanes << offset;
    endfunction

    assign is_load  = lsu_ctrl_i.valid && (lsu_ctrl_i.fu == lsu_pkg::LOAD);
    assign is_store = lsu_ctrl_i.valid && (lsu_ctrl_i.fu == lsu_pkg::STORE);
    assign be       = be_gen(lsu_ctrl_i.size, lsu_ctrl_i.vaddr[2:0]);

    // ----------------------------------------------------------------------
    // alignment
    // ----------------------------------------------------------------------
    always_comb begin : align_check
        unique case (lsu_ctrl_i.size)
            lsu_pkg::HALF:   misaligned = lsu_ctrl_i.vaddr[0];
            lsu_pkg::WORD:   misaligned = |lsu_ctrl_i.vaddr[1:0];
            lsu_pkg::DOUBLE: misaligned = |lsu_ctrl_i.vaddr[2:0];
            // byte never misaligned
            default:         misaligned = 1'b0;
        endcase
    end

    // ----------------------------------------------------------------------
    // exception, access fault wins over misalignment
    // ----------------------------------------------------------------------
    always_comb begin : exception_gen
        ex_o = '0;
        if (is_load || is_store) begin
            if (lsu_ctrl_i.canon_fault) begin
                ex_o.valid = 1'b1;
                ex_o.cause = is_load ? `LSU_XLEN'(`LSU_CAUSE_LD_ACCESS)
                                     : `LSU_XLEN'(`LSU_CAUSE_ST_ACCESS);
            end else if (misaligned) begin
                ex_o.valid = 1'b1;
                ex_o.cause = is_load ? `LSU_XLEN'(`LSU_CAUSE_LD_MISALIGNED)
                                     : `LSU_XLEN'(`LSU_CAUSE_ST_MISALIGNED);
            end
            // faulting address goes to tval
            if (ex_o.valid) begin
                ex_o.tval = `LSU_XLEN'(lsu_ctrl_i.vaddr);
            end
        end
    end

    // ----------------------------------------------------------------------
    // steering
    // ----------------------------------------------------------------------
    // shared payload, only the valids differ
    always_comb begin : req_payload
        req          = '0;
        req.vaddr    = lsu_ctrl_i.vaddr;
        req.wdata    = lsu_ctrl_i.wdata;
        req.be       = be;
        req.size     = lsu_ctrl_i.size;
        req.trans_id = lsu_ctrl_i.trans_id;
    end

    // valid stays up on exception so the unit can retire the op
    always_comb begin : steer
        ld_req_o       = req;
        st_req_o       = req;
        ld_req_o.valid = is_load;
        st_req_o.valid = is_store;
    end

endmodule

// ==== rtl/lsu_frontend.sv ====
// load/store front end top level
// agu and decoder build the queue entry, dispatch steers the queue head
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_frontend (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                en_translation_i,

    input  lsu_pkg::fu_data_t   fu_data_i,
    input  logic                lsu_valid_i,
    output logic                lsu_ready_o,

    // pulses from the consuming units
    input  logic                pop_ld_i,
    input  logic                pop_st_i,

    output lsu_pkg::mem_req_t   ld_req_o,
    output lsu_pkg::mem_req_t   st_req_o,
    output lsu_pkg::exception_t ex_o
);

    logic [`LSU_VLEN-1:0] vaddr;
    logic                 canon_fault;
    lsu_pkg::size_t       size;
    lsu_pkg::lsu_ctrl_t   lsu_req;
    lsu_pkg::lsu_ctrl_t   lsu_ctrl;

    lsu_agu i_lsu_agu (
        .fu_data_i        ( fu_data_i        ),
        .en_translation_i ( en_translation_i ),
        .vaddr_o          ( vaddr            ),
        .canon_fault_o    ( canon_fault      )
    );

    lsu_op_decode i_lsu_op_decode (
        .operator_i ( fu_data_i.operator ),
        .size_o     ( size               )
    );

    // ----------------------------------------------------------------------
    // queue entry
    // ----------------------------------------------------------------------
    assign lsu_req.valid       = lsu_valid_i;
    assign lsu_req.fu          = fu_data_i.fu;
    assign lsu_req.operator    = fu_data_i.operator;
    assign lsu_req.size        = size;
    assign lsu_req.vaddr       = vaddr;
    // store data comes from rs2
    assign lsu_req.wdata       = fu_data_i.operand_b;
    assign lsu_req.trans_id    = fu_data_i.trans_id;
    assign lsu_req.canon_fault = canon_fault;

    lsu_bypass i_lsu_bypass (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .flush_i    ( flush_i     ),
        .lsu_req_i  ( lsu_req     ),
        .pop_ld_i   ( pop_ld_i    ),
        .pop_st_i   ( pop_st_i    ),
        .lsu_ctrl_o ( lsu_ctrl    ),
        .ready_o    ( lsu_ready_o )
    );

    lsu_dispatch i_lsu_dispatch (
        .lsu_ctrl_i ( lsu_ctrl ),
        .ld_req_o   ( ld_req_o ),
        .st_req_o   ( st_req_o ),
        .ex_o       ( ex_o     )
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
// clock and reset source for the load/store front end testbench
// 4 ns clock, active-low reset held for 16 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // release just after an edge, like the other inputs
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_no = 1'b1;
    end

endmodule

// ==== verification/tb_lsu_frontend.sv ====
// directed testbench for the load/store front end
// reference model for address, byte enables and exceptions plus counted errors
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu_frontend;

    // reset 16 + random 48 + directed ~40 cycles with wide margin
    localparam int NUM_RANDOM     = 48;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                clk_i;
    logic                rst_n;
    logic                flush;
    logic                en_translation;
    lsu_pkg::fu_data_t   fu_data;
    logic                lsu_valid;
    logic                lsu_ready;
    logic                pop_ld;
    logic                pop_st;
    lsu_pkg::mem_req_t   ld_req;
    lsu_pkg::mem_req_t   st_req;
    lsu_pkg::exception_t ex;

    int          errors;
    int          checks;
    int          cycle_cnt;
    logic [31:0] rng_state;

    tb_clock_gen i_tb_clock_gen (
        .clk_o  ( clk_i ),
        .rst_no ( rst_n )
    );

    lsu_frontend i_lsu_frontend (
        .clk_i            ( clk_i          ),
        .rst_ni           ( rst_n          ),
        .flush_i          ( flush          ),
        .en_translation_i ( en_translation ),
        .fu_data_i        ( fu_data        ),
        .lsu_valid_i      ( lsu_valid      ),
        .lsu_ready_o      ( lsu_ready      ),
        .pop_ld_i         ( pop_ld         ),
        .pop_st_i         ( pop_st         ),
        .ld_req_o         ( ld_req         ),
        .st_req_o         ( st_req         ),
        .ex_o             ( ex             )
    );

    // ----------------------------------------------------------------------
    // stimulus helpers and reference model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // access width in bytes per operator
    function automatic int bytes_of_op(input lsu_pkg::op_t op);
        if (op == lsu_pkg::LD || op == lsu_pkg::SD) return 8;
        if (op == lsu_pkg::LW || op == lsu_pkg::LWU || op == lsu_pkg::SW) return 4;
        if (op == lsu_pkg::LH || op == lsu_pkg::LHU || op == lsu_pkg::SH) return 2;
        return 1;
    endfunction

    // lanes covered by the access and clipped at the 8-byte word
    function automatic logic [7:0] lane_enables(input logic [2:0] low, input int n);
        logic [7:0] lanes;
        int         off;
        off = int'(low);
        for (int i = 0; i < 8; i++) begin
            lanes[i] = (i >= off) && (i < off + n);
        end
        return lanes;
    endfunction

    // sv39 wants bits 63..38 all equal
    function automatic logic is_canonical(input logic [63:0] a);
        return (&a[63:`LSU_CANON_MSB]) || (a[63:`LSU_CANON_MSB] == '0);
    endfunction

    task automatic compare(input string name, input string field,
                           input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s expected %h actual %h", name, field, exp, act);
        end
    endtask

    // one op into an empty queue and popped in the same cycle
    task automatic issue_single(input string name, input lsu_pkg::fu_t fu,
                                input lsu_pkg::op_t op, input logic [63:0] base,
                                input logic [63:0] offs, input logic [63:0] data,
                                input logic [2:0] id, input logic en_tr);
        logic [63:0]       exp_addr;
        logic [7:0]        exp_be;
        logic              exp_ex;
        logic [63:0]       exp_cause;
        lsu_pkg::size_t    exp_size;
        int                n;
        lsu_pkg::mem_req_t got;
        lsu_pkg::mem_req_t other;
        exp_addr  = base + offs;
        n         = bytes_of_op(op);
        exp_be    = lane_enables(exp_addr[2:0], n);
        exp_ex    = 1'b0;
        exp_cause = '0;
        case (n)
            8:       exp_size = lsu_pkg::DOUBLE;
            4:       exp_size = lsu_pkg::WORD;
            2:       exp_size = lsu_pkg::HALF;
            default: exp_size = lsu_pkg::BYTE;
        endcase
        // access fault before alignment
        if (en_tr && !is_canonical(exp_addr)) begin
            exp_ex    = 1'b1;
            exp_cause = (fu == lsu_pkg::LOAD) ? 64'(`LSU_CAUSE_LD_ACCESS)
                                              : 64'(`LSU_CAUSE_ST_ACCESS);
        end else if ((exp_addr[2:0] & 3'(n - 1)) != 3'd0) begin
            exp_ex    = 1'b1;
            exp_cause = (fu == lsu_pkg::LOAD) ? 64'(`LSU_CAUSE_LD_MISALIGNED)
                                              : 64'(`LSU_CAUSE_ST_MISALIGNED);
        end
        fu_data.fu        = fu;
        fu_data.operator  = op;
        fu_data.operand_a = base;
        fu_data.operand_b = data;
        fu_data.imm       = offs;
        fu_data.trans_id  = id;
        en_translation    = en_tr;
        lsu_valid         = 1'b1;
        pop_ld            = (fu == lsu_pkg::LOAD);
        pop_st            = (fu == lsu_pkg::STORE);
        #2;
        got   = (fu == lsu_pkg::LOAD) ? ld_req : st_req;
        other = (fu == lsu_pkg::LOAD) ? st_req : ld_req;
        checks++;
        if (!got.valid || other.valid) begin
            errors++;
            $display("%s: request did not appear on the matching output", name);
        end
        compare(name, "vaddr", exp_addr, got.vaddr);
        compare(name, "be", 64'(exp_be), 64'(got.be));
        compare(name, "size", 64'(exp_size), 64'(got.size));
        compare(name, "wdata", data, got.wdata);
        compare(name, "trans_id", 64'(id), 64'(got.trans_id));
        compare(name, "ex.valid", 64'(exp_ex), 64'(ex.valid));
        if (exp_ex) begin
            compare(name, "ex.cause", exp_cause, ex.cause);
            compare(name, "ex.tval", exp_addr, ex.tval);
        end
        next_cycle();
        lsu_valid = 1'b0;
        pop_ld    = 1'b0;
        pop_st    = 1'b0;
    endtask

    // bounded wait until the store with this id reaches the head
    task automatic wait_for_store(input string name, input logic [2:0] id);
        logic found;
        found = 1'b0;
        for (int i = 0; i < 8 && !found; i++) begin
            #2;
            if (st_req.valid && st_req.trans_id == id) begin
                found = 1'b1;
            end
            next_cycle();
        end
        checks++;
        if (!found) begin
            errors++;
            $display("%s: store with trans_id %0d never reached the head", name, id);
        end
    endtask

    // load then store as from an issuer one cycle behind on ready
    task automatic fill_queue(input string name);
        fu_data          = '0;
        fu_data.fu       = lsu_pkg::LOAD;
        fu_data.operator = lsu_pkg::LD;
        fu_data.imm      = 64'h100;
        fu_data.trans_id = 3'd1;
        lsu_valid        = 1'b1;
        #2;
        compare(name, "ready before load", 64'd1, 64'(lsu_ready));
        compare(name, "load bypass id", 64'd1, 64'(ld_req.trans_id));
        next_cycle();
        fu_data.fu       = lsu_pkg::STORE;
        fu_data.operator = lsu_pkg::SW;
        fu_data.trans_id = 3'd2;
        #2;
        compare(name, "ready with load held", 64'd0, 64'(lsu_ready));
        next_cycle();
        lsu_valid = 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic reset_state_test();
        #2;
        compare("reset", "ready", 64'd1, 64'(lsu_ready));
        compare("reset", "ld valid", 64'd0, 64'(ld_req.valid));
        compare("reset", "st valid", 64'd0, 64'(st_req.valid));
        compare("reset", "ex valid", 64'd0, 64'(ex.valid));
        next_cycle();
    endtask

    task automatic aligned_random_test();
        logic [31:0]  r0;
        logic [31:0]  r1;
        logic [31:0]  r2;
        logic [31:0]  r3;
        lsu_pkg::op_t op;
        lsu_pkg::fu_t fu;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw(r0);
            draw(r1);
            draw(r2);
            draw(r3);
            if (r2[31]) begin
                fu = lsu_pkg::STORE;
                op = lsu_pkg::op_t'(4'(7 + r2[7:0] % 4));
            end else begin
                fu = lsu_pkg::LOAD;
                op = lsu_pkg::op_t'(4'(r2[7:0] % 7));
            end
            // 8-byte aligned base and immediate fit every size
            issue_single("aligned", fu, op, {r0, r1[31:3], 3'b000},
                         {{52{r2[23]}}, r2[23:15], 3'b000}, {r3, r1}, r2[10:8], 1'b0);
        end
    endtask

    task automatic misaligned_test();
        logic [63:0] base;
        base = 64'h0000_1234_5678_9ab0;
        issue_single("misaligned", lsu_pkg::LOAD, lsu_pkg::LH, base, 64'd1, '0, 3'd3, 1'b0);
        issue_single("misaligned", lsu_pkg::LOAD, lsu_pkg::LW, base, 64'd2, '0, 3'd4, 1'b0);
        issue_single("misaligned", lsu_pkg::LOAD, lsu_pkg::LD, base, 64'd4, '0, 3'd5, 1'b0);
        issue_single("misaligned", lsu_pkg::STORE, lsu_pkg::SH, base, 64'd3, '1, 3'd6, 1'b0);
        issue_single("misaligned", lsu_pkg::STORE, lsu_pkg::SW, base, 64'd1, '1, 3'd7, 1'b0);
        issue_single("misaligned", lsu_pkg::STORE, lsu_pkg::SD, base, -64'd2, '1, 3'd0, 1'b0);
    endtask

    task automatic canonical_test();
        logic [63:0] bad;
        logic [63:0] high;
        // bit 38 set with the bits above clear
        bad  = 64'h0000_0040_0000_0000;
        high = 64'hffff_ffc0_0000_1000;
        issue_single("canonical", lsu_pkg::LOAD, lsu_pkg::LD, bad, 64'd8, '0, 3'd1, 1'b1);
        issue_single("canonical", lsu_pkg::STORE, lsu_pkg::SW, bad, 64'd2, '1, 3'd2, 1'b1);
        issue_single("canonical", lsu_pkg::STORE, lsu_pkg::SW, bad, 64'd2, '1, 3'd3, 1'b0);
        issue_single("canonical", lsu_pkg::LOAD, lsu_pkg::LD, bad, 64'd8, '0, 3'd4, 1'b0);
        issue_single("canonical", lsu_pkg::LOAD, lsu_pkg::LW, high, 64'd4, '0, 3'd5, 1'b1);
    endtask

    task automatic queue_test();
        fill_queue("queue");
        #2;
        // load still at the head with the store behind it
        compare("queue", "held load valid", 64'd1, 64'(ld_req.valid));
        compare("queue", "held load id", 64'd1, 64'(ld_req.trans_id));
        compare("queue", "store hidden", 64'd0, 64'(st_req.valid));
        compare("queue", "ready held", 64'd0, 64'(lsu_ready));
        next_cycle();
        pop_ld = 1'b1;
        next_cycle();
        pop_ld = 1'b0;
        wait_for_store("queue", 3'd2);
        pop_st = 1'b1;
        next_cycle();
        pop_st = 1'b0;
        #2;
        compare("queue", "ready after pops", 64'd1, 64'(lsu_ready));
        compare("queue", "ld valid after pops", 64'd0, 64'(ld_req.valid));
        compare("queue", "st valid after pops", 64'd0, 64'(st_req.valid));
        next_cycle();
    endtask

    task automatic flush_test();
        fill_queue("flush");
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        #2;
        compare("flush", "ready", 64'd1, 64'(lsu_ready));
        compare("flush", "ld valid", 64'd0, 64'(ld_req.valid));
        compare("flush", "st valid", 64'd0, 64'(st_req.valid));
        compare("flush", "ex valid", 64'd0, 64'(ex.valid));
        next_cycle();
    endtask

    // ----------------------------------------------------------------------
    // run control
    // ----------------------------------------------------------------------
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        errors         = 0;
        checks         = 0;
        cycle_cnt      = 0;
        rng_state      = 32'ha8d6c6f1;
        flush          = 1'b0;
        en_translation = 1'b0;
        fu_data        = '0;
        lsu_valid      = 1'b0;
        pop_ld         = 1'b0;
        pop_st         = 1'b0;
        wait (rst_n === 1'b1);
        next_cycle();
        reset_state_test();
        aligned_random_test();
        misaligned_test();
        canonical_test();
        queue_test();
        flush_test();
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== lsu_frontend.f ====
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_op_decode.sv
rtl/lsu_bypass.sv
rtl/lsu_dispatch.sv
rtl/lsu_frontend.sv
verification/tb_clock_gen.sv
verification/tb_lsu_frontend.sv

// ==== run_lsu_frontend.sh ====
#!/bin/sh
# build the load/store front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim_lsu_frontend.log

rm -rf obj_dir

verilator --binary --timing \
    -f lsu_frontend.f \
    --top-module tb_lsu_frontend \
    -o sim_lsu_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_lsu_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0
